// ==== build.f ====
+incdir+.
gpio_pkg.sv
gpio_cfg_if.sv
gpio_reg_bank.sv
gpioa_mux.sv
uart_tx.sv
gpio_top.sv
gpio_assert.sv
tb_gpio.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the gpio port a testbench with verilator

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_gpio \
	-Mdir obj_dir -o tb_gpio_sim
if [ $? -ne 0 ]; then
	echo "verilator build step returned an error"
	exit 1
fi

./obj_dir/tb_gpio_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== tb_gpio.sv ====
// gpio port a testbench for register access, pad routing, input read-back and uart frames
`timescale 1ns/100ps
`include "gpio_cfg.svh"

module tb_gpio;

	localparam int CLK_NS = 40;
	localparam int DIV = `GPIO_UART_DIV;
	localparam int FRAME_CLKS = 10 * DIV;
	localparam int HS_LIMIT = 16;
	localparam int N_TESTS = 6;
	localparam int N_ROUNDS = 12;
	// a few frames and the bus traffic of the random rounds for each test
	localparam int WATCHDOG_CLKS = N_TESTS * (4 * FRAME_CLKS + 6 * N_ROUNDS * 8);

	logic module_clk;
	logic module_rstn;
	logic bus_req;
	logic bus_we;
	gpio_pkg::bus_addr_t bus_addr;
	gpio_pkg::bus_data_t bus_wdata;
	gpio_pkg::bus_data_t bus_rdata;
	logic bus_ack;
	gpio_pkg::pin_vec_t pad_out;
	gpio_pkg::pin_vec_t pad_oe;
	gpio_pkg::pin_vec_t pad_in;

	// model of the port registers
	gpio_pkg::pin_vec_t m_out;
	gpio_pkg::pin_vec_t m_dir;
	gpio_pkg::mode_vec_t m_mode;
	gpio_pkg::af_vec_t m_af;

	int errors;
	int err_mark;
	int n_tests;
	int n_passed;
	logic rx_armed;
	gpio_pkg::uart_byte_t rx_bytes[$];
	event pads_ev;

	gpio_top i_dut (
		.module_clk  (module_clk),
		.module_rstn (module_rstn),
		.bus_req     (bus_req),
		.bus_we      (bus_we),
		.bus_addr    (bus_addr),
		.bus_wdata   (bus_wdata),
		.bus_rdata   (bus_rdata),
		.bus_ack     (bus_ack),
		.pad_out     (pad_out),
		.pad_oe      (pad_oe),
		.pad_in      (pad_in)
	);

	initial
	begin
		module_clk = 1'b0;
		forever #(CLK_NS / 2) module_clk = ~module_clk;
	end

	// ========================================
	// reference model
	// ========================================

	// tx is the expected transmitter line level
	function automatic void ref_pads(
		input gpio_pkg::pin_vec_t sw_out, input gpio_pkg::pin_vec_t sw_dir,
		input gpio_pkg::mode_vec_t mode, input gpio_pkg::af_vec_t af,
		input gpio_pkg::pin_vec_t pins, input logic tx,
		output gpio_pkg::pin_vec_t e_out, output gpio_pkg::pin_vec_t e_oe,
		output gpio_pkg::pin_vec_t e_in, output logic e_rx);
		logic alt;
		for (int i = 0; i < `GPIO_PINS; i++)
		begin
			alt = (mode[2*i +: 2] == `GPIO_MODE_ALT);
			// software pins pass the registers to the pad and the pad level back
			e_out[i] = alt ? 1'b0 : sw_out[i];
			e_oe[i] = alt ? 1'b0 : sw_dir[i];
			e_in[i] = alt ? 1'b0 : pins[i];
		end
		// uart tx on pin 0
		if ((mode[1:0] == `GPIO_MODE_ALT) && (af[1:0] == `GPIO_AF_UART))
		begin
			e_out[0] = tx;
			e_oe[0] = 1'b1;
		end
		// rx level from pin 1 or idle high
		e_rx = ((mode[3:2] == `GPIO_MODE_ALT) && (af[3:2] == `GPIO_AF_UART)) ?
			pins[1] : 1'b1;
	endfunction

	// ========================================
	// compare tasks
	// ========================================

	task automatic check_pins(input string name, input gpio_pkg::pin_vec_t got,
		input gpio_pkg::pin_vec_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input string name, input gpio_pkg::bus_data_t got,
		input gpio_pkg::bus_data_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input gpio_pkg::uart_byte_t got,
		input gpio_pkg::uart_byte_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// ========================================
	// bus and timing helpers
	// ========================================

	// land 2 ns after the rising edge, where inputs change
	task automatic wait_clks(input int n);
		repeat (n) @(posedge module_clk);
		#2;
	endtask

	task automatic bus_access(input logic we, input gpio_pkg::bus_addr_t addr,
		input gpio_pkg::bus_data_t wdata, output gpio_pkg::bus_data_t rdata);
		int waited;
		waited = 0;
		bus_req = 1'b1;
		bus_we = we;
		bus_addr = addr;
		bus_wdata = wdata;
		// ack and rdata sampled on the falling edge
		@(negedge module_clk);
		while (!bus_ack && waited < HS_LIMIT)
		begin
			@(negedge module_clk);
			waited++;
		end
		if (!bus_ack)
		begin
			$display("handshake error: no ack for access to address %0d", addr);
			errors++;
		end
		rdata = bus_rdata;
		wait_clks(1);
		bus_req = 1'b0;
		waited = 0;
		@(negedge module_clk);
		while (bus_ack && waited < HS_LIMIT)
		begin
			@(negedge module_clk);
			waited++;
		end
		if (bus_ack)
		begin
			$display("handshake error: ack still high after req was released");
			errors++;
		end
		wait_clks(1);
	endtask

	task automatic bus_write(input gpio_pkg::bus_addr_t addr,
		input gpio_pkg::bus_data_t data);
		gpio_pkg::bus_data_t unused;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input gpio_pkg::bus_addr_t addr,
		output gpio_pkg::bus_data_t data);
		bus_access(1'b0, addr, '0, data);
	endtask

	// write and keep the model in step
	task automatic set_register(input gpio_pkg::bus_addr_t addr,
		input gpio_pkg::bus_data_t data);
		bus_write(addr, data);
		case (addr)
			`GPIO_ADDR_OUT:  m_out = gpio_pkg::pin_vec_t'(data);
			`GPIO_ADDR_DIR:  m_dir = gpio_pkg::pin_vec_t'(data);
			`GPIO_ADDR_MODE: m_mode = data;
			`GPIO_ADDR_AF:   m_af = data;
			default: ;
		endcase
	endtask

	task automatic read_expect(input gpio_pkg::bus_addr_t addr,
		input gpio_pkg::bus_data_t exp);
		gpio_pkg::bus_data_t got;
		bus_read(addr, got);
		check_data($sformatf("bus_rdata addr %0d", addr), got, exp);
	endtask

	task automatic report_test(input string name);
		n_tests++;
		if (errors == err_mark)
		begin
			n_passed++;
			$display("test %0d %s: ok", n_tests, name);
		end
		else
			$display("test %0d %s: %0d error(s)", n_tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	// ========================================
	// pad compare and uart decoder
	// ========================================

	// transmitter idle at every compare
	initial
	begin : pad_compare
		gpio_pkg::pin_vec_t e_out;
		gpio_pkg::pin_vec_t e_oe;
		gpio_pkg::pin_vec_t e_in;
		logic e_rx;
		forever
		begin
			@(pads_ev);
			ref_pads(m_out, m_dir, m_mode, m_af, pad_in, 1'b1, e_out, e_oe, e_in, e_rx);
			check_pins("pad_out", pad_out, e_out);
			check_pins("pad_oe", pad_oe, e_oe);
		end
	end

	// falling edge seen within half a clock, then sample mid-bit
	initial
	begin : uart_decoder
		gpio_pkg::uart_byte_t got;
		forever
		begin
			@(negedge module_clk);
			if (rx_armed && !pad_out[0])
			begin
				repeat (DIV / 2) @(negedge module_clk);
				if (pad_out[0])
				begin
					$display("start bit on pin 0 ended early");
					errors++;
				end
				for (int b = 0; b < 8; b++)
				begin
					repeat (DIV) @(negedge module_clk);
					got[b] = pad_out[0];
				end
				repeat (DIV) @(negedge module_clk);
				if (!pad_out[0])
				begin
					$display("stop bit on pin 0 missing");
					errors++;
				end
				rx_bytes.push_back(got);
			end
		end
	end

	initial
	begin : watchdog
		#(WATCHDOG_CLKS * CLK_NS);
		$display("watchdog: run did not finish within %0d clocks", WATCHDOG_CLKS);
		$display("Test failed");
		$finish;
	end

	// ========================================
	// tests
	// ========================================

	initial
	begin : main
		gpio_pkg::pin_vec_t e_out;
		gpio_pkg::pin_vec_t e_oe;
		gpio_pkg::pin_vec_t e_in;
		logic e_rx;
		gpio_pkg::bus_data_t val;
		gpio_pkg::uart_byte_t sent;
		int waited;
		void'($urandom(32'h1555_788c));
		module_rstn = 1'b0;
		bus_req = 1'b0;
		bus_we = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		pad_in = '0;
		m_out = '0;
		m_dir = '0;
		m_mode = '0;
		m_af = '0;
		rx_armed = 1'b0;
		errors = 0;
		err_mark = 0;
		n_tests = 0;
		n_passed = 0;
		repeat (3) @(posedge module_clk);
		#2;
		module_rstn = 1'b1;
		wait_clks(1);

		// reset state with the uart word showing rx idle high
		check_pins("pad_oe", pad_oe, '0);
		check_pins("pad_out", pad_out, '0);
		for (int a = 0; a < 8; a++)
			read_expect(gpio_pkg::bus_addr_t'(a), (a == 5) ? 32'h2 : 32'h0);
		report_test("reset values");

		// unused upper bits of OUT and DIR read 0
		for (int r = 0; r < 4; r++)
		begin
			val = $urandom;
			set_register(`GPIO_ADDR_OUT, val);
			read_expect(`GPIO_ADDR_OUT, gpio_pkg::bus_data_t'(gpio_pkg::pin_vec_t'(val)));
			val = $urandom;
			set_register(`GPIO_ADDR_DIR, val);
			read_expect(`GPIO_ADDR_DIR, gpio_pkg::bus_data_t'(gpio_pkg::pin_vec_t'(val)));
			val = $urandom;
			set_register(`GPIO_ADDR_MODE, val);
			read_expect(`GPIO_ADDR_MODE, val);
			val = $urandom;
			set_register(`GPIO_ADDR_AF, val);
			read_expect(`GPIO_ADDR_AF, val);
		end
		report_test("register readback");

		for (int r = 0; r < N_ROUNDS; r++)
		begin
			pad_in = gpio_pkg::pin_vec_t'($urandom);
			set_register(`GPIO_ADDR_OUT, $urandom);
			set_register(`GPIO_ADDR_DIR, $urandom);
			set_register(`GPIO_ADDR_MODE, $urandom);
			set_register(`GPIO_ADDR_AF, $urandom);
			wait_clks(2);
			-> pads_ev;
			wait_clks(1);
		end
		report_test("pad routing");

		for (int r = 0; r < N_ROUNDS; r++)
		begin
			set_register(`GPIO_ADDR_MODE, $urandom);
			set_register(`GPIO_ADDR_AF, $urandom);
			pad_in = gpio_pkg::pin_vec_t'($urandom);
			wait_clks(3);
			ref_pads(m_out, m_dir, m_mode, m_af, pad_in, 1'b1, e_out, e_oe, e_in, e_rx);
			read_expect(`GPIO_ADDR_IN, gpio_pkg::bus_data_t'(e_in));
		end
		report_test("input readback");

		// pin 0 to uart tx while pin 1 stays software
		set_register(`GPIO_ADDR_MODE, 32'h2);
		set_register(`GPIO_ADDR_AF, 32'h0);
		wait_clks(2);
		-> pads_ev;
		wait_clks(1);
		rx_armed = 1'b1;
		sent = gpio_pkg::uart_byte_t'($urandom);
		bus_write(`GPIO_ADDR_UART, gpio_pkg::bus_data_t'(sent));
		read_expect(`GPIO_ADDR_UART, 32'h3);
		// dropped while the transmitter is busy
		bus_write(`GPIO_ADDR_UART, gpio_pkg::bus_data_t'(~sent));
		waited = 0;
		while (rx_bytes.size() == 0 && waited < FRAME_CLKS + 4 * DIV)
		begin
			wait_clks(1);
			waited++;
		end
		if (rx_bytes.size() == 0)
		begin
			$display("no start bit seen on pin 0 after uart write");
			errors++;
		end
		else
			check_byte("uart byte", rx_bytes.pop_front(), sent);
		wait_clks(DIV + 2);
		read_expect(`GPIO_ADDR_UART, 32'h2);
		wait_clks(FRAME_CLKS + 2 * DIV);
		if (rx_bytes.size() != 0)
		begin
			$display("a frame was sent for the uart write issued while busy");
			errors++;
		end
		rx_armed = 1'b0;
		report_test("uart transmit");

		// pin 1 to uart rx and then back to software
		set_register(`GPIO_ADDR_MODE, 32'h8);
		for (int v = 0; v < 2; v++)
		begin
			pad_in = gpio_pkg::pin_vec_t'($urandom);
			pad_in[1] = v[0];
			wait_clks(4);
			ref_pads(m_out, m_dir, m_mode, m_af, pad_in, 1'b1, e_out, e_oe, e_in, e_rx);
			read_expect(`GPIO_ADDR_UART, {30'd0, e_rx, 1'b0});
		end
		set_register(`GPIO_ADDR_MODE, 32'h0);
		pad_in[1] = 1'b0;
		wait_clks(4);
		ref_pads(m_out, m_dir, m_mode, m_af, pad_in, 1'b1, e_out, e_oe, e_in, e_rx);
		read_expect(`GPIO_ADDR_UART, {30'd0, e_rx, 1'b0});
		report_test("uart rx status");

		$display("tests run %0d, passed %0d, failed checks %0d", n_tests, n_passed, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== gpio_assert.sv ====
// gpio port a checker for bus handshake rules, the uart line and pad enables after reset
`timescale 1ns/100ps

module gpio_assert (
	input logic               module_clk,
	input logic               module_rstn,
	input logic               bus_req,
	input logic               bus_ack,
	input logic               tx_busy,
	input logic               tx_line,
	input gpio_pkg::pin_vec_t pad_oe
);

	// ack only answers a request seen on the edge before
	ack_needs_req: assert property (@(posedge module_clk) disable iff (!module_rstn)
		$rose(bus_ack) |-> $past(bus_req))
		else $error("bus_ack rose while bus_req was low");

	// four-phase ack held until req released
	ack_held: assert property (@(posedge module_clk) disable iff (!module_rstn)
		(bus_ack && bus_req) |=> bus_ack)
		else $error("bus_ack dropped before bus_req fell");

	// line back high through the stop bit before busy drops
	tx_idle_high: assert property (@(posedge module_clk) disable iff (!module_rstn)
		$fell(tx_busy) |-> $past(tx_line))
		else $error("tx_line low in the last cycle before the transmitter went idle");

	// no pad driven in the first cycle out of reset
	oe_after_reset: assert property (@(posedge module_clk)
		$rose(module_rstn) |-> (pad_oe == '0))
		else $error("pad_oe not zero right after reset");

endmodule

bind gpio_top gpio_assert i_assert (
	.module_clk  (module_clk),
	.module_rstn (module_rstn),
	.bus_req     (bus_req),
	.bus_ack     (bus_ack),
	.tx_busy     (tx_busy),
	.tx_line     (tx_line),
	.pad_oe      (pad_oe)
);

// ==== gpio_top.sv ====
// gpio port a top: register bank, alternate function mux and uart transmitter
`timescale 1ns/100ps

module gpio_top (
	input  logic                  module_clk,
	input  logic                  module_rstn,
	// register bus
	input  logic                  bus_req,
	input  logic                  bus_we,
	input  gpio_pkg::bus_addr_t   bus_addr,
	input  gpio_pkg::bus_data_t   bus_wdata,
	output gpio_pkg::bus_data_t   bus_rdata,
	output logic                  bus_ack,
	// pads, oe 1 means driven
	output gpio_pkg::pin_vec_t    pad_out,
	output gpio_pkg::pin_vec_t    pad_oe,
	input  gpio_pkg::pin_vec_t    pad_in
);

	// transmitter link
	logic tx_start;
	gpio_pkg::uart_byte_t tx_data;
	logic tx_busy;
	logic tx_line;

	// configuration and read-back between bank and mux
	gpio_cfg_if i_cfg_if ();

	gpio_reg_bank i_reg_bank (
		.module_clk  (module_clk),
		.module_rstn (module_rstn),
		.bus_req     (bus_req),
		.bus_we      (bus_we),
		.bus_addr    (bus_addr),
		.bus_wdata   (bus_wdata),
		.bus_rdata   (bus_rdata),
		.bus_ack     (bus_ack),
		.cfg         (i_cfg_if.bank),
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.tx_busy     (tx_busy)
	);

	gpioa_mux i_mux (
		.module_clk  (module_clk),
		.module_rstn (module_rstn),
		.cfg         (i_cfg_if.mux),
		.tx_line     (tx_line),
		.pad_out     (pad_out),
		.pad_oe      (pad_oe),
		.pad_in      (pad_in)
	);

	// alternate source for pin 0
	uart_tx i_uart_tx (
		.module_clk  (module_clk),
		.module_rstn (module_rstn),
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.tx_busy     (tx_busy),
		.tx_line     (tx_line)
	);

endmodule

// ==== uart_tx.sv ====
// uart transmitter: fixed rate 8N1 frame per start pulse
`timescale 1ns/100ps
`include "gpio_cfg.svh"

module uart_tx (
	input  logic                   module_clk,
	input  logic                   module_rstn,
	input  logic                   tx_start,
	input  gpio_pkg::uart_byte_t   tx_data,
	output logic                   tx_busy,
	output logic                   tx_line
);

	localparam int DIV = `GPIO_UART_DIV;
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	gpio_pkg::uart_state_e state_q;
	logic [CNT_W-1:0] cnt_q;
	logic [2:0] bit_idx;
	gpio_pkg::uart_byte_t shift_q;
	logic bit_end;

	// last clock of the current bit period
	assign bit_end = (cnt_q == CNT_W'(DIV - 1));
	assign tx_busy = (state_q != gpio_pkg::UART_IDLE);

	// ========================================
	// frame sequencing
	// ========================================

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			state_q <= gpio_pkg::UART_IDLE;
			cnt_q <= '0;
			bit_idx <= '0;
		end
		else
		begin
			// bit timer runs only inside a frame
			if (!tx_busy || bit_end)
				cnt_q <= '0;
			else
				cnt_q <= cnt_q + 1'b1;
			case (state_q)
				gpio_pkg::UART_IDLE:
					if (tx_start)
						state_q <= gpio_pkg::UART_START;
				gpio_pkg::UART_START:
					if (bit_end)
					begin
						state_q <= gpio_pkg::UART_DATA;
						bit_idx <= '0;
					end
				gpio_pkg::UART_DATA:
					if (bit_end)
					begin
						bit_idx <= bit_idx + 1'b1;
						// eighth data bit done
						if (bit_idx == 3'd7)
							state_q <= gpio_pkg::UART_STOP;
					end
				default:
					if (bit_end)
						state_q <= gpio_pkg::UART_IDLE;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge module_clk)
	begin
		if (!tx_busy && tx_start)
			shift_q <= tx_data;
		else if ((state_q == gpio_pkg::UART_DATA) && bit_end)
			shift_q <= shift_q >> 1;
	end

	// line level per state, high when idle or stop
	always_comb
	begin
		case (state_q)
			gpio_pkg::UART_START: tx_line = 1'b0;
			gpio_pkg::UART_DATA:  tx_line = shift_q[0];
			default:              tx_line = 1'b1;
		endcase
	end

endmodule

// ==== gpioa_mux.sv ====
// gpio port a alternate function mux for per pin software or hardware pad control
`timescale 1ns/100ps
`include "gpio_cfg.svh"

module gpioa_mux (
	input  logic                 module_clk,
	input  logic                 module_rstn,
	// from register bank
	gpio_cfg_if.mux              cfg,
	// uart transmit level for pin 0
	input  logic                 tx_line,
	// pads
	output gpio_pkg::pin_vec_t   pad_out,
	output gpio_pkg::pin_vec_t   pad_oe,
	input  gpio_pkg::pin_vec_t   pad_in
);

	// 1 hardware control, 0 software control
	gpio_pkg::pin_vec_t hw_ctl;
	// registered alternate select of pins 0 and 1
	logic [3:0] hw_af;
	logic uart_tx_sel;
	logic uart_rx_sel;

	// ========================================
	// mode and select registers
	// ========================================

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			hw_ctl <= '0;
			hw_af <= '0;
		end
		else
		begin
			// decode each two-bit mode field
			for (int i = 0; i < `GPIO_PINS; i++)
			begin
				hw_ctl[i] <= (cfg.mode[2*i +: 2] == `GPIO_MODE_ALT);
			end
			hw_af <= cfg.af[3:0];
		end
	end

	// uart pair only on pins 0 and 1 with select 0
	assign uart_tx_sel = hw_ctl[0] && (hw_af[1:0] == `GPIO_AF_UART);
	assign uart_rx_sel = hw_ctl[1] && (hw_af[3:2] == `GPIO_AF_UART);

	// ========================================
	// pad routing
	// ========================================

	always_comb
	begin
		for (int i = 0; i < `GPIO_PINS; i++)
		begin
			if (hw_ctl[i])
			begin
				// unused alternate functions park the pad
				pad_out[i] = 1'b0;
				pad_oe[i] = 1'b0;
				cfg.pin_in[i] = 1'b0;
			end
			else
			begin
				pad_out[i] = cfg.sw_out[i];
				pad_oe[i] = cfg.sw_dir[i];
				cfg.pin_in[i] = pad_in[i];
			end
		end
		// pin 0 driven by the transmitter
		if (uart_tx_sel)
		begin
			pad_out[0] = tx_line;
			pad_oe[0] = 1'b1;
		end
	end

	// pin 1 is input only with the enable left off
	assign cfg.uart_rx = uart_rx_sel ? pad_in[1] : 1'b1;

endmodule

// ==== gpio_reg_bank.sv ====
// gpio register bank: four-phase bus slave, port registers, uart launch, input sync
`timescale 1ns/100ps
`include "gpio_cfg.svh"

module gpio_reg_bank (
	input  logic                   module_clk,
	input  logic                   module_rstn,
	// register bus
	input  logic                   bus_req,
	input  logic                   bus_we,
	input  gpio_pkg::bus_addr_t    bus_addr,
	input  gpio_pkg::bus_data_t    bus_wdata,
	output gpio_pkg::bus_data_t    bus_rdata,
	output logic                   bus_ack,
	// towards the mux
	gpio_cfg_if.bank               cfg,
	// transmitter launch
	output logic                   tx_start,
	output gpio_pkg::uart_byte_t   tx_data,
	input  logic                   tx_busy
);

	gpio_pkg::bus_state_e state_q;
	gpio_pkg::pin_vec_t in_meta;
	gpio_pkg::pin_vec_t in_sync;
	logic rx_meta;
	logic rx_sync;
	gpio_pkg::bus_data_t rd_val;
	logic access;

	// ========================================
	// handshake
	// ========================================

	// new request seen while idle
	assign access = (state_q == gpio_pkg::BUS_IDLE) && bus_req;
	assign bus_ack = (state_q == gpio_pkg::BUS_ACK);

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
			state_q <= gpio_pkg::BUS_IDLE;
		else if (access)
			state_q <= gpio_pkg::BUS_ACK;
		// hold ack until master lets go of req
		else if (bus_ack && !bus_req)
			state_q <= gpio_pkg::BUS_IDLE;
	end

	// ========================================
	// port registers and uart launch
	// ========================================

	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			cfg.sw_out <= '0;
			cfg.sw_dir <= '0;
			cfg.mode <= '0;
			cfg.af <= '0;
			tx_start <= 1'b0;
		end
		else
		begin
			// single cycle pulse
			tx_start <= 1'b0;
			if (access && bus_we)
			begin
				case (bus_addr)
					`GPIO_ADDR_OUT:  cfg.sw_out <= bus_wdata[`GPIO_PINS-1:0];
					`GPIO_ADDR_DIR:  cfg.sw_dir <= bus_wdata[`GPIO_PINS-1:0];
					`GPIO_ADDR_MODE: cfg.mode <= bus_wdata;
					`GPIO_ADDR_AF:   cfg.af <= bus_wdata;
					// dropped while a frame is on the line
					`GPIO_ADDR_UART: tx_start <= !tx_busy;
					default: ;
				endcase
			end
		end
	end

	// byte and read data only sampled when qualified
	always_ff @(posedge module_clk)
	begin
		if (access && bus_we && (bus_addr == `GPIO_ADDR_UART) && !tx_busy)
			tx_data <= bus_wdata[7:0];
		if (access)
			bus_rdata <= bus_we ? '0 : rd_val;
	end

	// ========================================
	// read mux and input synchronizers
	// ========================================

	always_comb
	begin
		case (bus_addr)
			`GPIO_ADDR_OUT:  rd_val = gpio_pkg::bus_data_t'(cfg.sw_out);
			`GPIO_ADDR_DIR:  rd_val = gpio_pkg::bus_data_t'(cfg.sw_dir);
			`GPIO_ADDR_MODE: rd_val = cfg.mode;
			`GPIO_ADDR_AF:   rd_val = cfg.af;
			`GPIO_ADDR_IN:   rd_val = gpio_pkg::bus_data_t'(in_sync);
			// bit 0 busy, bit 1 rx level
			`GPIO_ADDR_UART: rd_val = {30'd0, rx_sync, tx_busy};
			default:         rd_val = '0;
		endcase
	end

	// two flops, rx rests at idle high
	always_ff @(posedge module_clk or negedge module_rstn)
	begin
		if (!module_rstn)
		begin
			in_meta <= '0;
			in_sync <= '0;
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			in_meta <= cfg.pin_in;
			in_sync <= in_meta;
			rx_meta <= cfg.uart_rx;
			rx_sync <= rx_meta;
		end
	end

endmodule

// ==== gpio_cfg_if.sv ====
// gpio configuration link between register bank and alternate function mux
`timescale 1ns/100ps

interface gpio_cfg_if;

	// software output levels and drive enables
	gpio_pkg::pin_vec_t sw_out;
	gpio_pkg::pin_vec_t sw_dir;
	// per pin mode and alternate select
	gpio_pkg::mode_vec_t mode;
	gpio_pkg::af_vec_t af;
	// pad levels of software pins, 0 on alternate pins
	gpio_pkg::pin_vec_t pin_in;
	// routed receive level, idle high
	logic uart_rx;

	// register bank side
	modport bank (
		output sw_out, sw_dir, mode, af,
		input pin_in, uart_rx
	);

	// mux side
	modport mux (
		input sw_out, sw_dir, mode, af,
		output pin_in, uart_rx
	);

endinterface

// ==== gpio_pkg.sv ====
// gpio port a shared types: port vectors, bus words and state machine encodings
`include "gpio_cfg.svh"

package gpio_pkg;

	// one bit per pin
	typedef logic [`GPIO_PINS-1:0] pin_vec_t;
	// two bits per pin of mode
	typedef logic [2*`GPIO_PINS-1:0] mode_vec_t;
	// two bits per pin of alternate select
	typedef logic [2*`GPIO_PINS-1:0] af_vec_t;

	// register bus
	typedef logic [2:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// one serial byte
	typedef logic [7:0] uart_byte_t;

	// four-phase slave
	typedef enum logic {BUS_IDLE, BUS_ACK} bus_state_e;

	// 8N1 frame sequencing
	typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

endpackage

// ==== gpio_cfg.svh ====
// gpio port a configuration: pin count, register map, mode codes and uart bit rate
`ifndef GPIO_CFG_SVH
`define GPIO_CFG_SVH

// number of port pins
`define GPIO_PINS 16

// register word addresses
`define GPIO_ADDR_OUT  3'd0
`define GPIO_ADDR_DIR  3'd1
`define GPIO_ADDR_MODE 3'd2
`define GPIO_ADDR_AF   3'd3
`define GPIO_ADDR_IN   3'd4
`define GPIO_ADDR_UART 3'd5

// mode code that hands a pin to hardware
`define GPIO_MODE_ALT 2'd2
// alternate select of the uart pair
`define GPIO_AF_UART  2'd0

// clocks per serial bit
`define GPIO_UART_DIV 8

`endif
